// File: design/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Lanes per fetch bundle, 1 to 8
`define DECODE_WIDTH 4

`define ILEN 32

// Holds any lane count up to 8
`define LANE_CNT_W 4

`endif

// File: design/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // Shared by imm, reg and word forms
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA variants
    localparam logic [5:0] F6_SRL  = 6'b000000; // Also the left shift pattern
    localparam logic [5:0] F6_SRA  = 6'b010000;

    typedef enum logic [5:0] {
        OP_NONE,
        ADDI, XORI, ORI, ANDI, SLTI, SLTIU, SLLI, SRLI, SRAI,
        ADD, SUB, AND, OR, XOR, SLL, SLT, SLTU, SRL, SRA,
        ADDIW, SLLIW, SRLIW, SRAIW, ADDW, SUBW, SLLW, SRLW, SRAW,
        LD, LB, LH, LW, LBU, LHU, LWU,
        SD, SB, SH, SW,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } op_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LT,
        ALU_LTU, ALU_SL, ALU_SR, ALU_SRU, ALU_SRW, ALU_SRUW, ALU_DIRECT
    } alu_func_e;

endpackage

`default_nettype wire

// File: design/decode_pkg.sv
`default_nettype none

`include "decode_config.svh"

package decode_pkg;
    import riscv_isa_pkg::*;

    typedef logic [`ILEN-1:0] instr_t;

    // One decoded lane
    typedef struct packed {
        op_e       op;
        alu_func_e alu_func;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      illegal;   // No pattern matched
        logic      valid;     // Lane below the bundle's count
    } control_t;

    typedef struct packed {
        instr_t [`DECODE_WIDTH-1:0]  instr;
        logic   [`LANE_CNT_W-1:0]    lane_cnt;
    } fetch_bundle_t;

    typedef struct packed {
        control_t [`DECODE_WIDTH-1:0] ctl;
    } decode_bundle_t;

endpackage

`default_nettype wire

// File: design/fetch_latch.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module fetch_latch
    import decode_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  fetch_bundle_t              in_bundle,
    input  logic                       buf_ready,
    output logic                       latch_valid,
    output instr_t [`DECODE_WIDTH-1:0] lane_instr,
    output logic   [`DECODE_WIDTH-1:0] lane_valid
);

    logic          full_q;
    fetch_bundle_t bundle_q;
    logic          take;

    assign in_ready = !full_q || buf_ready; // Empty or draining this cycle
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            bundle_q <= in_bundle;
        end
    end

    assign latch_valid = full_q;
    assign lane_instr  = bundle_q.instr;

    always_comb begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            lane_valid[i] = `LANE_CNT_W'(i) < bundle_q.lane_cnt;
        end
    end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module instr_decoder
    import riscv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [`ILEN-1:0] instr,
    output control_t         ctl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];

    function automatic control_t ctl_word(op_e op, alu_func_e fn, logic rw, logic rd, logic wr);
        control_t c;
        c           = '0;
        c.op        = op;
        c.alu_func  = fn;
        c.reg_write = rw;
        c.mem_read  = rd;
        c.mem_write = wr;
        return c;
    endfunction

    // Register-writing ALU operation
    function automatic control_t alu_op(op_e op, alu_func_e fn);
        return ctl_word(op, fn, 1'b1, 1'b0, 1'b0);
    endfunction

    always_comb begin
        ctl = '0;
        unique case (opcode)
            OPC_OP_IMM: begin
                unique case (funct3)
                    F3_ADD_SUB: ctl = alu_op(ADDI, ALU_ADD);
                    F3_XOR:     ctl = alu_op(XORI, ALU_XOR);
                    F3_OR:      ctl = alu_op(ORI, ALU_OR);
                    F3_AND:     ctl = alu_op(ANDI, ALU_AND);
                    F3_SLT:     ctl = alu_op(SLTI, ALU_LT);
                    F3_SLTU:    ctl = alu_op(SLTIU, ALU_LTU);
                    F3_SLL:     if (funct6 == F6_SRL) ctl = alu_op(SLLI, ALU_SL);
                    F3_SRL_SRA: begin
                        if (funct6 == F6_SRL) begin
                            ctl = alu_op(SRLI, ALU_SRU);
                        end else if (funct6 == F6_SRA) begin
                            ctl = alu_op(SRAI, ALU_SR);
                        end
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                unique case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_BASE) begin
                            ctl = alu_op(ADD, ALU_ADD);
                        end else if (funct7 == F7_ALT) begin
                            ctl = alu_op(SUB, ALU_SUB);
                        end
                    end
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) begin
                            ctl = alu_op(SRL, ALU_SRU);
                        end else if (funct7 == F7_ALT) begin
                            ctl = alu_op(SRA, ALU_SR);
                        end
                    end
                    F3_AND:  if (funct7 == F7_BASE) ctl = alu_op(AND, ALU_AND);
                    F3_OR:   if (funct7 == F7_BASE) ctl = alu_op(OR, ALU_OR);
                    F3_XOR:  if (funct7 == F7_BASE) ctl = alu_op(XOR, ALU_XOR);
                    F3_SLL:  if (funct7 == F7_BASE) ctl = alu_op(SLL, ALU_SL);
                    F3_SLT:  if (funct7 == F7_BASE) ctl = alu_op(SLT, ALU_LT);
                    F3_SLTU: if (funct7 == F7_BASE) ctl = alu_op(SLTU, ALU_LTU);
                    default: ;
                endcase
            end
            OPC_OP_IMM_32: begin
                unique case (funct3)
                    F3_ADD_SUB: ctl = alu_op(ADDIW, ALU_ADD);
                    F3_SLL:     if (funct6 == F6_SRL) ctl = alu_op(SLLIW, ALU_SL);
                    F3_SRL_SRA: begin
                        if (funct6 == F6_SRL) begin
                            ctl = alu_op(SRLIW, ALU_SRUW);
                        end else if (funct6 == F6_SRA) begin
                            ctl = alu_op(SRAIW, ALU_SRW);
                        end
                    end
                    default: ;
                endcase
            end
            OPC_OP_32: begin
                unique case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_BASE) begin
                            ctl = alu_op(ADDW, ALU_ADD);
                        end else if (funct7 == F7_ALT) begin
                            ctl = alu_op(SUBW, ALU_SUB);
                        end
                    end
                    F3_SLL: if (funct7 == F7_BASE) ctl = alu_op(SLLW, ALU_SL);
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) begin
                            ctl = alu_op(SRLW, ALU_SRUW);
                        end else if (funct7 == F7_ALT) begin
                            ctl = alu_op(SRAW, ALU_SRW);
                        end
                    end
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                unique case (funct3)
                    F3_LD:   ctl = ctl_word(LD, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LB:   ctl = ctl_word(LB, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LH:   ctl = ctl_word(LH, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LW:   ctl = ctl_word(LW, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LBU:  ctl = ctl_word(LBU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LHU:  ctl = ctl_word(LHU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LWU:  ctl = ctl_word(LWU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    default: ;
                endcase
            end
            OPC_STORE: begin
                unique case (funct3)
                    F3_SD:   ctl = ctl_word(SD, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SB:   ctl = ctl_word(SB, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SH:   ctl = ctl_word(SH, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SW:   ctl = ctl_word(SW, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    default: ;
                endcase
            end
            OPC_LUI:   ctl = alu_op(LUI, ALU_DIRECT); // Immediate passes straight through
            OPC_AUIPC: ctl = alu_op(AUIPC, ALU_ADD);
            OPC_JAL:   ctl = alu_op(JAL, ALU_ADD);    // Link address pc + 4
            OPC_JALR:  if (funct3 == F3_JALR) ctl = alu_op(JALR, ALU_ADD);
            OPC_BRANCH: begin
                unique case (funct3)
                    F3_BEQ:  ctl = ctl_word(BEQ, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BNE:  ctl = ctl_word(BNE, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BLT:  ctl = ctl_word(BLT, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BGE:  ctl = ctl_word(BGE, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BLTU: ctl = ctl_word(BLTU, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BGEU: ctl = ctl_word(BGEU, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    default: ;
                endcase
            end
            default: ;
        endcase

        // Nothing matched
        if (ctl.op == OP_NONE) begin
            ctl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module issue_buffer
    import decode_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         latch_valid,
    output logic                         buf_ready,
    input  control_t [`DECODE_WIDTH-1:0] lane_ctl,
    input  logic     [`DECODE_WIDTH-1:0] lane_valid,
    output logic                         out_valid,
    input  logic                         out_ready,
    output decode_bundle_t               out_bundle
);

    logic           full_q;
    decode_bundle_t bundle_d;
    decode_bundle_t bundle_q;

    assign buf_ready = !full_q || out_ready;

    // Lanes past the count go out as all zero
    always_comb begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            bundle_d.ctl[i] = '0;
            if (lane_valid[i]) begin
                bundle_d.ctl[i]       = lane_ctl[i];
                bundle_d.ctl[i].valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (buf_ready) begin
            full_q <= latch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_ready && latch_valid) begin
            bundle_q <= bundle_d;
        end
    end

    assign out_valid  = full_q;
    assign out_bundle = bundle_q;

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    output logic           in_ready,
    input  fetch_bundle_t  in_bundle,
    output logic           out_valid,
    input  logic           out_ready,
    output decode_bundle_t out_bundle
);

    instr_t   [`DECODE_WIDTH-1:0] lane_instr;
    logic     [`DECODE_WIDTH-1:0] lane_valid;
    control_t [`DECODE_WIDTH-1:0] lane_ctl;
    logic                         latch_valid;
    logic                         buf_ready;

    fetch_latch i_fetch_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_bundle   (in_bundle),
        .buf_ready   (buf_ready),
        .latch_valid (latch_valid),
        .lane_instr  (lane_instr),
        .lane_valid  (lane_valid)
    );

    for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : g_lane
        instr_decoder i_instr_decoder (
            .instr (lane_instr[i]),
            .ctl   (lane_ctl[i])
        );
    end

    issue_buffer i_issue_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .latch_valid (latch_valid),
        .buf_ready   (buf_ready),
        .lane_ctl    (lane_ctl),
        .lane_valid  (lane_valid),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_bundle  (out_bundle)
    );

endmodule

`default_nettype wire

// File: bench/decode_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decode_assertions
    import decode_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input logic           in_ready,
    input logic           latch_valid,
    input logic           out_valid,
    input logic           out_ready,
    input decode_bundle_t out_bundle
);

    property hold_under_stall;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle);
    endproperty

    a_hold_under_stall: assert property (hold_under_stall)
        else $error("out_valid or out_bundle changed while out_ready was low");

    // Both stages empty once reset is seen
    a_empty_after_reset: assert property (
        @(posedge clk) !rst_n |=> !out_valid && !latch_valid && in_ready
    ) else $error("Stage not empty and ready after reset");

    // Input stalls only with both stages full behind a blocked output
    a_stall_needs_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        !in_ready |-> latch_valid && out_valid && !out_ready
    ) else $error("in_ready low while the output side was not stalled");

endmodule

bind decode_stage decode_assertions i_decode_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready    (in_ready),
    .latch_valid (latch_valid),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_bundle  (out_bundle)
);

`default_nettype wire

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module tb_decode_stage
    import riscv_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int          NUM_BUNDLES    = 400;
    localparam int          TIMEOUT_CYCLES = NUM_BUNDLES * 20;
    localparam logic [31:0] SEED           = 32'hf903_0780;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           in_valid;
    logic           in_ready;
    fetch_bundle_t  in_bundle;
    logic           out_valid;
    logic           out_ready;
    decode_bundle_t out_bundle;

    logic [31:0]    lfsr;
    logic           in_taken;
    decode_bundle_t exp_q[$];
    int             error_cnt;
    int             check_cnt;
    int             issued_cnt;
    int             sent_cnt;
    int             recv_cnt;
    int             cycle_cnt;

    always #50 clk = ~clk;

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h8020_0003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_instr();
        logic [31:0] w;
        opcode_e     opc;
        int          pick;
        w = rand_bits(32);
        if (rand_bits(2) != 0) begin // Kept opcode most of the time
            opc  = opc.first();
            pick = rand_bits(4) % 11;
            repeat (pick) opc = opc.next();
            w[6:0] = opc;
            if (rand_bits(1) == 1) begin
                w[31:25] = (rand_bits(1) == 1) ? F7_ALT : F7_BASE;
            end
        end
        return w;
    endfunction

    function automatic fetch_bundle_t new_bundle();
        fetch_bundle_t b;
        b.lane_cnt = `LANE_CNT_W'(rand_bits(4) % (`DECODE_WIDTH + 1));
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            b.instr[i] = rand_instr();
        end
        return b;
    endfunction

    function automatic control_t op_and_func(input op_e op, input alu_func_e fn);
        control_t c;
        c          = '0;
        c.op       = op;
        c.alu_func = fn;
        return c;
    endfunction

    // Pattern is {funct7, funct3, opcode}
    function automatic control_t model_decode(input logic [31:0] w);
        control_t   c;
        logic [6:0] opc;
        c   = '0;
        opc = w[6:0];
        casez ({w[31:25], w[14:12], opc})
            17'b???????_000_0010011: c = op_and_func(ADDI, ALU_ADD);
            17'b???????_100_0010011: c = op_and_func(XORI, ALU_XOR);
            17'b???????_110_0010011: c = op_and_func(ORI, ALU_OR);
            17'b???????_111_0010011: c = op_and_func(ANDI, ALU_AND);
            17'b???????_010_0010011: c = op_and_func(SLTI, ALU_LT);
            17'b???????_011_0010011: c = op_and_func(SLTIU, ALU_LTU);
            17'b000000?_001_0010011: c = op_and_func(SLLI, ALU_SL);
            17'b000000?_101_0010011: c = op_and_func(SRLI, ALU_SRU);
            17'b010000?_101_0010011: c = op_and_func(SRAI, ALU_SR);
            17'b0000000_000_0110011: c = op_and_func(ADD, ALU_ADD);
            17'b0100000_000_0110011: c = op_and_func(SUB, ALU_SUB);
            17'b0000000_101_0110011: c = op_and_func(SRL, ALU_SRU);
            17'b0100000_101_0110011: c = op_and_func(SRA, ALU_SR);
            17'b0000000_111_0110011: c = op_and_func(AND, ALU_AND);
            17'b0000000_110_0110011: c = op_and_func(OR, ALU_OR);
            17'b0000000_100_0110011: c = op_and_func(XOR, ALU_XOR);
            17'b0000000_001_0110011: c = op_and_func(SLL, ALU_SL);
            17'b0000000_010_0110011: c = op_and_func(SLT, ALU_LT);
            17'b0000000_011_0110011: c = op_and_func(SLTU, ALU_LTU);
            17'b???????_000_0011011: c = op_and_func(ADDIW, ALU_ADD);
            17'b000000?_001_0011011: c = op_and_func(SLLIW, ALU_SL);
            17'b000000?_101_0011011: c = op_and_func(SRLIW, ALU_SRUW);
            17'b010000?_101_0011011: c = op_and_func(SRAIW, ALU_SRW);
            17'b0000000_000_0111011: c = op_and_func(ADDW, ALU_ADD);
            17'b0100000_000_0111011: c = op_and_func(SUBW, ALU_SUB);
            17'b0000000_001_0111011: c = op_and_func(SLLW, ALU_SL);
            17'b0000000_101_0111011: c = op_and_func(SRLW, ALU_SRUW);
            17'b0100000_101_0111011: c = op_and_func(SRAW, ALU_SRW);
            17'b???????_011_0000011: c = op_and_func(LD, ALU_NOP);
            17'b???????_000_0000011: c = op_and_func(LB, ALU_NOP);
            17'b???????_001_0000011: c = op_and_func(LH, ALU_NOP);
            17'b???????_010_0000011: c = op_and_func(LW, ALU_NOP);
            17'b???????_100_0000011: c = op_and_func(LBU, ALU_NOP);
            17'b???????_101_0000011: c = op_and_func(LHU, ALU_NOP);
            17'b???????_110_0000011: c = op_and_func(LWU, ALU_NOP);
            17'b???????_011_0100011: c = op_and_func(SD, ALU_DIRECT);
            17'b???????_000_0100011: c = op_and_func(SB, ALU_DIRECT);
            17'b???????_001_0100011: c = op_and_func(SH, ALU_DIRECT);
            17'b???????_010_0100011: c = op_and_func(SW, ALU_DIRECT);
            17'b???????_???_0110111: c = op_and_func(LUI, ALU_DIRECT);
            17'b???????_???_0010111: c = op_and_func(AUIPC, ALU_ADD);
            17'b???????_???_1101111: c = op_and_func(JAL, ALU_ADD);
            17'b???????_000_1100111: c = op_and_func(JALR, ALU_ADD);
            17'b???????_000_1100011: c = op_and_func(BEQ, ALU_NOP);
            17'b???????_001_1100011: c = op_and_func(BNE, ALU_NOP);
            17'b???????_100_1100011: c = op_and_func(BLT, ALU_NOP);
            17'b???????_101_1100011: c = op_and_func(BGE, ALU_NOP);
            17'b???????_110_1100011: c = op_and_func(BLTU, ALU_NOP);
            17'b???????_111_1100011: c = op_and_func(BGEU, ALU_NOP);
            default: ;
        endcase
        c.illegal   = (c.op == OP_NONE);
        c.reg_write = !c.illegal && opc != OPC_STORE && opc != OPC_BRANCH;
        c.mem_read  = !c.illegal && opc == OPC_LOAD;
        c.mem_write = !c.illegal && opc == OPC_STORE;
        return c;
    endfunction

    function automatic decode_bundle_t expected_bundle(input fetch_bundle_t b);
        decode_bundle_t e;
        e = '0;
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            if (i < int'(b.lane_cnt)) begin
                e.ctl[i]       = model_decode(b.instr[i]);
                e.ctl[i].valid = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            error_cnt++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Scoreboard and timeout
    always @(posedge clk) begin
        decode_bundle_t want;
        cycle_cnt++;
        in_taken = 1'b0;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_bundle(in_bundle));
                sent_cnt++;
                in_taken = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    error_cnt++;
                    $display("Output bundle %0d came out with no input bundle waiting", recv_cnt);
                end else begin
                    want = exp_q.pop_front();
                    for (int i = 0; i < `DECODE_WIDTH; i++) begin
                        check_equal($sformatf("bundle %0d lane %0d", recv_cnt, i),
                                    32'(want.ctl[i]), 32'(out_bundle.ctl[i]));
                    end
                end
                recv_cnt++;
            end
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d bundles came out",
                     cycle_cnt, recv_cnt, NUM_BUNDLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        lfsr      = SEED;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_bundle = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (issued_cnt < NUM_BUNDLES || in_valid) begin
            @(negedge clk);
            out_ready = rand_bits(2) != 0;
            if (in_valid && in_taken) in_valid = 1'b0;
            if (!in_valid && issued_cnt < NUM_BUNDLES && rand_bits(2) != 0) begin
                in_bundle = new_bundle();
                in_valid  = 1'b1;
                issued_cnt++;
            end
        end

        while (recv_cnt < NUM_BUNDLES) begin
            @(negedge clk);
            out_ready = rand_bits(2) != 0;
        end
        out_ready = 1'b1;
        repeat (4) @(negedge clk); // Any extra bundle shows up here

        if (exp_q.size() != 0) begin
            $display("%0d accepted bundles never came out", exp_q.size());
        end
        $display("Bundles in %0d, bundles out %0d, checks %0d, errors %0d",
                 sent_cnt, recv_cnt, check_cnt, error_cnt);
        if (error_cnt == 0 && exp_q.size() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/riscv_isa_pkg.sv
design/decode_pkg.sv
design/fetch_latch.sv
design/instr_decoder.sv
design/issue_buffer.sv
design/decode_stage.sv
bench/decode_assertions.sv
bench/tb_decode_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_decode_stage -f list.f -Mdir obj_dir
./obj_dir/Vtb_decode_stage > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
exit 1
